//--- rtl/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire                           advance_i,
    input  wire                           valid_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rs1_addr_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rs2_addr_i,
    input  wire [rv_pkg::XLEN-1:0]        rs1_data_i,
    input  wire [rv_pkg::XLEN-1:0]        rs2_data_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rd_addr_i,
    input  wire [rv_pkg::IMM_WIDTH-1:0]   imm_i,
    input  wire rv_pkg::alu_op_e          alu_op_i,
    input  wire                           use_imm_i,
    input  wire                           we_i,
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o,
    output logic                          wb_we_o
);

    logic                    fwd_ok;
    logic                    fwd_rs1;
    logic                    fwd_rs2;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b_reg;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic                    lt_s;
    logic                    lt_u;
    logic [rv_pkg::XLEN-1:0] result;

    // previous instruction still sits in the write-back register
    assign fwd_ok  = wb_valid_o && wb_we_o && (wb_rd_o != '0);
    assign fwd_rs1 = fwd_ok && (wb_rd_o == rs1_addr_i);
    assign fwd_rs2 = fwd_ok && (wb_rd_o == rs2_addr_i);

    assign op_a     = fwd_rs1 ? wb_data_o : rs1_data_i;
    assign op_b_reg = fwd_rs2 ? wb_data_o : rs2_data_i;
    assign op_b     = use_imm_i ? imm_i : op_b_reg;

    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD:  result = op_a + op_b;
            rv_pkg::ALU_SUB:  result = op_a - op_b;
            rv_pkg::ALU_SLL:  result = op_a << shamt;
            rv_pkg::ALU_SLT:  result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            rv_pkg::ALU_XOR:  result = op_a ^ op_b;
            rv_pkg::ALU_SRL:  result = op_a >> shamt;
            rv_pkg::ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:   result = op_a | op_b;
            rv_pkg::ALU_AND:  result = op_a & op_b;
            rv_pkg::ALU_LUI:  result = imm_i;
            default:          result = op_a + op_b;
        endcase
    end

    // ex/wb control
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
        end else if (advance_i) begin
            wb_valid_o <= valid_i;
            // a bubble never writes
            wb_we_o    <= valid_i && we_i;
        end
    end

    // ex/wb payload
    always_ff @(posedge clk) begin
        if (advance_i) begin
            wb_rd_o   <= rd_addr_i;
            wb_data_o <= result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire                           advance_i,
    input  wire                           valid_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rs1_addr_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rs2_addr_i,
    input  wire [rv_pkg::XLEN-1:0]        rs1_data_i,
    input  wire [rv_pkg::XLEN-1:0]        rs2_data_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rd_addr_i,
    input  wire [rv_pkg::IMM_WIDTH-1:0]   imm_i,
    input  wire rv_pkg::alu_op_e          alu_op_i,
    input  wire                           use_imm_i,
    input  wire                           we_i,
    input  wire                           wb_we_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  wb_rd_i,
    input  wire [rv_pkg::XLEN-1:0]        wb_data_i,
    output logic                          valid_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] rs2_addr_o,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] rd_addr_o,
    output logic [rv_pkg::IMM_WIDTH-1:0]  imm_o,
    output rv_pkg::alu_op_e               alu_op_o,
    output logic                          use_imm_o,
    output logic                          we_o
);

    logic byp_rs1;
    logic byp_rs2;

    // value committing this cycle is not yet visible in the register file
    assign byp_rs1 = wb_we_i && (wb_rd_i == rs1_addr_i) && (rs1_addr_i != '0);
    assign byp_rs2 = wb_we_i && (wb_rd_i == rs2_addr_i) && (rs2_addr_i != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            we_o    <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
            we_o    <= we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            rs1_addr_o <= rs1_addr_i;
            rs2_addr_o <= rs2_addr_i;
            rs1_data_o <= byp_rs1 ? wb_data_i : rs1_data_i;
            rs2_data_o <= byp_rs2 ? wb_data_i : rs2_data_i;
            rd_addr_o  <= rd_addr_i;
            imm_o      <= imm_i;
            alu_op_o   <= alu_op_i;
            use_imm_o  <= use_imm_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire [rv_pkg::XLEN-1:0]        inst_i,
    output logic [rv_pkg::REG_AWIDTH-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] rs2_addr_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] rd_addr_o,
    output logic [rv_pkg::IMM_WIDTH-1:0]  imm_o,
    output rv_pkg::alu_op_e               alu_op_o,
    output logic                          use_imm_o,
    output logic                          we_o
);

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic                           inst_b30;
    logic [rv_pkg::IMM_WIDTH-1:0]   i_imm;
    logic [rv_pkg::IMM_WIDTH-1:0]   u_imm;
    logic [rv_pkg::IMM_WIDTH-1:0]   shamt_imm;

    assign opcode   = inst_i[6:0];
    assign funct3   = inst_i[14:12];
    assign inst_b30 = inst_i[30];

    assign rd_addr_o  = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign i_imm     = {{(rv_pkg::IMM_WIDTH-12){inst_i[31]}}, inst_i[31:20]};
    assign u_imm     = {inst_i[31:12], 12'b0};
    // immediate shifts keep only the shift amount
    assign shamt_imm = {{(rv_pkg::IMM_WIDTH-5){1'b0}}, inst_i[24:20]};

    always_comb begin
        imm_o     = i_imm;
        alu_op_o  = rv_pkg::ALU_ADD;
        use_imm_o = 1'b0;
        we_o      = 1'b0;

        case (opcode)
            rv_pkg::OPC_OP: begin
                we_o = 1'b1;
                case (funct3)
                    rv_pkg::F3_ADD:  alu_op_o = inst_b30 ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLL:  alu_op_o = rv_pkg::ALU_SLL;
                    rv_pkg::F3_SLT:  alu_op_o = rv_pkg::ALU_SLT;
                    rv_pkg::F3_SLTU: alu_op_o = rv_pkg::ALU_SLTU;
                    rv_pkg::F3_XOR:  alu_op_o = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SR:   alu_op_o = inst_b30 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    rv_pkg::F3_OR:   alu_op_o = rv_pkg::ALU_OR;
                    default:         alu_op_o = rv_pkg::ALU_AND;
                endcase
            end

            rv_pkg::OPC_OP_IMM: begin
                we_o      = 1'b1;
                use_imm_o = 1'b1;
                case (funct3)
                    // no subtract form with an immediate
                    rv_pkg::F3_ADD:  alu_op_o = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLL: begin
                        alu_op_o = rv_pkg::ALU_SLL;
                        imm_o    = shamt_imm;
                    end
                    rv_pkg::F3_SLT:  alu_op_o = rv_pkg::ALU_SLT;
                    rv_pkg::F3_SLTU: alu_op_o = rv_pkg::ALU_SLTU;
                    rv_pkg::F3_XOR:  alu_op_o = rv_pkg::ALU_XOR;
                    rv_pkg::F3_SR: begin
                        alu_op_o = inst_b30 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        imm_o    = shamt_imm;
                    end
                    rv_pkg::F3_OR:   alu_op_o = rv_pkg::ALU_OR;
                    default:         alu_op_o = rv_pkg::ALU_AND;
                endcase
            end

            rv_pkg::OPC_LUI: begin
                we_o     = 1'b1;
                imm_o    = u_imm;
                alu_op_o = rv_pkg::ALU_LUI;
            end

            // anything else retires without a write
            default: begin
                we_o     = 1'b0;
                alu_op_o = rv_pkg::ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/int_core.sv
`timescale 1ns/1ps
`default_nettype none

module int_core (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire                           inst_valid_i,
    input  wire [rv_pkg::XLEN-1:0]        inst_i,
    output logic                          inst_ready_o,
    output logic                          commit_valid_o,
    output logic [rv_pkg::REG_AWIDTH-1:0] commit_rd_o,
    output logic [rv_pkg::XLEN-1:0]       commit_data_o,
    output logic                          commit_we_o,
    input  wire                           commit_ready_i
);

    // decode outputs
    logic [rv_pkg::REG_AWIDTH-1:0] dec_rs1_addr;
    logic [rv_pkg::REG_AWIDTH-1:0] dec_rs2_addr;
    logic [rv_pkg::REG_AWIDTH-1:0] dec_rd_addr;
    logic [rv_pkg::IMM_WIDTH-1:0]  dec_imm;
    rv_pkg::alu_op_e               dec_alu_op;
    logic                          dec_use_imm;
    logic                          dec_we;
    logic [rv_pkg::XLEN-1:0]       rf_rs1_data;
    logic [rv_pkg::XLEN-1:0]       rf_rs2_data;

    // id_ex outputs
    logic                          ex_valid;
    logic [rv_pkg::REG_AWIDTH-1:0] ex_rs1_addr;
    logic [rv_pkg::REG_AWIDTH-1:0] ex_rs2_addr;
    logic [rv_pkg::XLEN-1:0]       ex_rs1_data;
    logic [rv_pkg::XLEN-1:0]       ex_rs2_data;
    logic [rv_pkg::REG_AWIDTH-1:0] ex_rd_addr;
    logic [rv_pkg::IMM_WIDTH-1:0]  ex_imm;
    rv_pkg::alu_op_e               ex_alu_op;
    logic                          ex_use_imm;
    logic                          ex_we;

    // write-back register
    logic                          wb_valid;
    logic [rv_pkg::REG_AWIDTH-1:0] wb_rd;
    logic [rv_pkg::XLEN-1:0]       wb_data;
    logic                          wb_we;

    logic run_q;
    logic advance;
    logic rf_we;

    // keeps the input closed while reset is applied
    always_ff @(posedge clk) begin
        if (rst_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // commit back-pressure freezes the whole pipe
    assign advance      = run_q && (!wb_valid || commit_ready_i);
    assign inst_ready_o = advance;

    // register file write happens on the commit handshake
    assign rf_we = wb_valid && commit_ready_i && wb_we;

    assign commit_valid_o = wb_valid;
    assign commit_rd_o    = wb_rd;
    assign commit_data_o  = wb_data;
    assign commit_we_o    = wb_we;

    inst_decode i_inst_decode (
        .inst_i     (inst_i),
        .rs1_addr_o (dec_rs1_addr),
        .rs2_addr_o (dec_rs2_addr),
        .rd_addr_o  (dec_rd_addr),
        .imm_o      (dec_imm),
        .alu_op_o   (dec_alu_op),
        .use_imm_o  (dec_use_imm),
        .we_o       (dec_we)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (dec_rs1_addr),
        .rs2_addr_i (dec_rs2_addr),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (wb_rd),
        .rd_data_i  (wb_data)
    );

    id_ex i_id_ex (
        .clk        (clk),
        .rst_i      (rst_i),
        .advance_i  (advance),
        .valid_i    (inst_valid_i),
        .rs1_addr_i (dec_rs1_addr),
        .rs2_addr_i (dec_rs2_addr),
        .rs1_data_i (rf_rs1_data),
        .rs2_data_i (rf_rs2_data),
        .rd_addr_i  (dec_rd_addr),
        .imm_i      (dec_imm),
        .alu_op_i   (dec_alu_op),
        .use_imm_i  (dec_use_imm),
        .we_i       (dec_we),
        .wb_we_i    (rf_we),
        .wb_rd_i    (wb_rd),
        .wb_data_i  (wb_data),
        .valid_o    (ex_valid),
        .rs1_addr_o (ex_rs1_addr),
        .rs2_addr_o (ex_rs2_addr),
        .rs1_data_o (ex_rs1_data),
        .rs2_data_o (ex_rs2_data),
        .rd_addr_o  (ex_rd_addr),
        .imm_o      (ex_imm),
        .alu_op_o   (ex_alu_op),
        .use_imm_o  (ex_use_imm),
        .we_o       (ex_we)
    );

    alu_exec i_alu_exec (
        .clk        (clk),
        .rst_i      (rst_i),
        .advance_i  (advance),
        .valid_i    (ex_valid),
        .rs1_addr_i (ex_rs1_addr),
        .rs2_addr_i (ex_rs2_addr),
        .rs1_data_i (ex_rs1_data),
        .rs2_data_i (ex_rs2_data),
        .rd_addr_i  (ex_rd_addr),
        .imm_i      (ex_imm),
        .alu_op_i   (ex_alu_op),
        .use_imm_i  (ex_use_imm),
        .we_i       (ex_we),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data),
        .wb_we_o    (wb_we)
    );

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rs1_addr_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  wire                           we_i,
    input  wire [rv_pkg::REG_AWIDTH-1:0]  rd_addr_i,
    input  wire [rv_pkg::XLEN-1:0]        rd_data_i
);

    localparam int unsigned NUM_REGS = 2 ** rv_pkg::REG_AWIDTH;

    // x0 has no storage
    logic [rv_pkg::XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_addr_i != '0)) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // plain reads, same-cycle writes are patched in id_ex
    always_comb begin
        rs1_data_o = '0;
        rs2_data_o = '0;
        if (rs1_addr_i != '0) begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i != '0) begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // datapath widths
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_AWIDTH = 5;
    localparam int unsigned IMM_WIDTH  = 32;

    // major opcodes handled by the execute slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 for the integer alu group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    // srl and sra share funct3, split by instruction bit 30
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // alu operation carried from decode into execute
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        // result is the immediate itself
        ALU_LUI  = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

//--- sim.f
rtl/rv_pkg.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/id_ex.sv
rtl/alu_exec.sv
rtl/int_core.sv
verif/tb_int_core.sv

//--- verif/tb_int_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;

    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT    = 200;

    logic                          clk;
    logic                          rst_i;
    logic                          inst_valid_i;
    logic [rv_pkg::XLEN-1:0]       inst_i;
    logic                          inst_ready_o;
    logic                          commit_valid_o;
    logic [rv_pkg::REG_AWIDTH-1:0] commit_rd_o;
    logic [rv_pkg::XLEN-1:0]       commit_data_o;
    logic                          commit_we_o;
    logic                          commit_ready_i;

    integer seed       = 32'h470b_5b04;
    // separate stream for commit ready keeps stimulus independent of it
    integer ready_seed = 32'h470b_5b04 ^ 32'h0000_ffff;

    logic                    backpressure;
    int                      n_sent;
    int                      n_done;
    string                   test_name;
    logic [rv_pkg::XLEN-1:0] sent_q [$];
    logic [rv_pkg::XLEN-1:0] ref_regs [0:31];

    int_core i_int_core (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_ready_o   (inst_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o),
        .commit_we_o    (commit_we_o),
        .commit_ready_i (commit_ready_i)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_data(input string name, input logic [rv_pkg::XLEN-1:0] exp,
                              input logic [rv_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s data: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [rv_pkg::REG_AWIDTH-1:0] exp,
                            input logic [rv_pkg::REG_AWIDTH-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s rd: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_we(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s bit: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s cycles: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // architectural result of one instruction against the model registers
    function automatic void ref_exec(input logic [31:0] word, output logic [4:0] rd,
                                     output logic [31:0] data, output logic we);
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        opc  = word[6:0];
        rd   = word[11:7];
        a    = ref_regs[word[19:15]];
        b    = (opc == rv_pkg::OPC_OP) ? ref_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        data = '0;
        we   = (opc == rv_pkg::OPC_OP) || (opc == rv_pkg::OPC_OP_IMM) || (opc == rv_pkg::OPC_LUI);
        if (opc == rv_pkg::OPC_LUI) begin
            data = {word[31:12], 12'h000};
        end else if (we) begin
            case (word[14:12])
                rv_pkg::F3_ADD:  data = (opc == rv_pkg::OPC_OP && word[30]) ? a - b : a + b;
                rv_pkg::F3_SLL:  data = a << b[4:0];
                rv_pkg::F3_SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                rv_pkg::F3_SLTU: data = (a < b) ? 32'd1 : 32'd0;
                rv_pkg::F3_XOR:  data = a ^ b;
                rv_pkg::F3_SR: begin
                    if (word[30]) data = $signed(a) >>> b[4:0];
                    else data = a >> b[4:0];
                end
                rv_pkg::F3_OR:   data = a | b;
                default:         data = a & b;
            endcase
        end
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic b30,
                                          input logic [4:0] rd, rs1, rs2);
        return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rv_pkg::OPC_LUI};
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[4:0];
    endfunction

    // random alu word, mostly register and immediate forms, some lui
    function automatic logic [31:0] rand_alu(input logic [4:0] rd, rs1, rs2);
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [11:0] imm;
        rnd = $random(seed);
        f3  = rnd[2:0];
        imm = rnd[31:20];
        if (rnd[6:4] == 3'd7) return enc_lui(rd, rnd[31:12]);
        if (rnd[6:4] < 3'd4) begin
            return enc_r(f3, rnd[7] && (f3 == rv_pkg::F3_ADD || f3 == rv_pkg::F3_SR),
                         rd, rs1, rs2);
        end
        if (f3 == rv_pkg::F3_SLL) imm = {7'b0, rnd[24:20]};
        if (f3 == rv_pkg::F3_SR) imm = {1'b0, rnd[7], 5'b0, rnd[24:20]};
        return enc_i(f3, rd, rs1, imm);
    endfunction

    // starts and ends on a falling edge
    task automatic send_inst(input logic [rv_pkg::XLEN-1:0] word);
        int   waited;
        logic took;
        waited       = 0;
        took         = 1'b0;
        inst_valid_i = 1'b1;
        inst_i       = word;
        while (!took) begin
            #2;
            took = inst_ready_o;
            if (took) begin
                sent_q.push_back(word);
                n_sent++;
            end
            @(negedge clk);
            waited++;
            if (!took && waited > TIMEOUT) begin
                $display("instruction not accepted within %0d cycles", TIMEOUT);
                abort_run();
            end
        end
        inst_valid_i = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        logic [31:0] rnd;
        rnd          = $random(seed);
        inst_valid_i = 1'b0;
        inst_i       = rnd;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (n_done != n_sent) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("pipeline did not drain within %0d cycles", TIMEOUT);
                abort_run();
            end
        end
    endtask

    // rs1 reads the previous rd, rs2 the one before it
    task automatic run_chain(input int count, input logic gaps);
        logic [4:0] prev1;
        logic [4:0] prev2;
        logic [4:0] rd;
        logic [4:0] pick;
        int         k;
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (k = 0; k < count; k++) begin
            rd = rand_reg();
            if (rd == 5'd0) rd = 5'd9;
            send_inst(rand_alu(rd, prev1, prev2));
            prev2 = prev1;
            prev1 = rd;
            pick  = rand_reg();
            if (gaps && pick < 5'd8) idle_cycles(1 + pick[1:0]);
        end
    endtask

    initial begin : commit_checker
        logic [rv_pkg::REG_AWIDTH-1:0] exp_rd;
        logic [rv_pkg::XLEN-1:0]       exp_data;
        logic                          exp_we;
        logic [rv_pkg::XLEN-1:0]       word;
        int                            idle;
        idle = 0;
        forever begin
            @(negedge clk);
            commit_ready_i = backpressure ? (($random(ready_seed) & 3) != 0) : 1'b1;
            #2;
            if (commit_valid_o && commit_ready_i) begin
                if (sent_q.size() == 0) begin
                    $display("commit seen with no instruction outstanding");
                    abort_run();
                end
                word = sent_q.pop_front();
                ref_exec(word, exp_rd, exp_data, exp_we);
                check_rd(test_name, exp_rd, commit_rd_o);
                check_we(test_name, exp_we, commit_we_o);
                if (exp_we) check_data(test_name, exp_data, commit_data_o);
                if (exp_we && exp_rd != 5'd0) ref_regs[exp_rd] = exp_data;
                n_done++;
                idle = 0;
            end else if (sent_q.size() != 0) begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("no commit for %0d cycles with work outstanding", TIMEOUT);
                    abort_run();
                end
            end
        end
    end

    initial begin : stimulus
        logic [5:0]  r;
        logic [31:0] rnd;
        int          lat;
        int          i;
        clk            = 1'b0;
        rst_i          = 1'b1;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        commit_ready_i = 1'b0;
        backpressure   = 1'b0;
        n_sent         = 0;
        n_done         = 0;
        test_name      = "reset";
        for (i = 0; i < 32; i++) ref_regs[i] = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_we("reset_commit_valid", 1'b0, commit_valid_o);
        check_we("reset_inst_ready", 1'b0, inst_ready_o);
        rst_i = 1'b0;

        // first result two edges after acceptance
        test_name = "latency";
        send_inst(enc_i(rv_pkg::F3_ADD, 5'd5, 5'd0, 12'h123));
        lat = 1;
        #2;
        while (!commit_valid_o) begin
            @(negedge clk);
            #2;
            lat++;
            if (lat > TIMEOUT) begin
                $display("first commit never appeared");
                abort_run();
            end
        end
        check_count("latency", 2, lat);
        // back onto the falling edge before driving again
        @(negedge clk);
        drain();

        test_name = "alu_ops";
        for (r = 6'd1; r < 6'd32; r++) begin
            rnd = $random(seed);
            send_inst(enc_lui(r[4:0], rnd[31:12]));
            send_inst(enc_i(rv_pkg::F3_ADD, r[4:0], r[4:0], rnd[11:0]));
        end
        for (i = 0; i < 300; i++) begin
            send_inst(rand_alu(rand_reg(), rand_reg(), rand_reg()));
            if (($random(seed) & 3) == 0) idle_cycles(1 + ($random(seed) & 3));
        end
        drain();

        test_name = "dep_chain";
        run_chain(200, 1'b0);
        drain();

        test_name    = "backpressure";
        backpressure = 1'b1;
        run_chain(400, 1'b1);
        drain();

        // x0 write then read, and unsupported opcodes followed by a readback
        test_name = "x0_and_illegal";
        send_inst(enc_i(rv_pkg::F3_ADD, 5'd0, 5'd5, 12'h7ff));
        send_inst(enc_r(rv_pkg::F3_OR, 1'b0, 5'd6, 5'd0, 5'd0));
        for (i = 0; i < 40; i++) begin
            rnd = $random(seed);
            if (rnd[6:0] == rv_pkg::OPC_OP || rnd[6:0] == rv_pkg::OPC_OP_IMM ||
                rnd[6:0] == rv_pkg::OPC_LUI) begin
                rnd[6:0] = 7'b0000011;
            end
            send_inst(rnd);
            send_inst(enc_r(rv_pkg::F3_ADD, 1'b0, rand_reg(), rnd[11:7], 5'd0));
        end
        drain();

        if (n_done == n_sent && sent_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("sent %0d instructions but %0d committed", n_sent, n_done);
            abort_run();
        end
    end

endmodule

`default_nettype wire
